/* photon_counter_pkg.sv */
package photon_counter_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and depths.
    ////////////////////////////////////////////////////////////
    localparam int COUNT_W         = 32;    // Photon count width.
    localparam int HIST_DEPTH      = 16;    // History entries.

    // 133.333333 MHz / 115200 bps.
    localparam int BAUD_DIV        = 1157;  // Clocks per UART bit.
    localparam int FRAME_BITS      = 11;    // Start, 8 data, 2 stop.
    localparam int BYTES_PER_COUNT = 4;     // MSB first on the line.

    typedef logic [COUNT_W-1:0]            count_t;      // One window count.
    typedef logic [$clog2(HIST_DEPTH)-1:0] hist_addr_t;  // History slot index.

    ////////////////////////////////////////////////////////////
    // State machines.
    ////////////////////////////////////////////////////////////

    // Logger step sequence.
    typedef enum logic [2:0] {
        LOG_IDLE,       // Waiting for a closed window.
        LOG_WRITE,      // Store the count.
        LOG_READ,       // Fetch it back.
        LOG_SEND_REQ,   // Present one byte to the UART.
        LOG_SEND_WAIT,  // Wait for the frame to finish.
        LOG_NEXT_BYTE   // Wait for ack low, pick next byte.
    } logger_state_t;

    // Memory arbiter.
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SERVE_WR,    // Logger write granted.
        ST_SERVE_RD,    // Logger read granted.
        ST_SERVE_HOST,  // Host read granted.
        ST_RELEASE      // Hold ack until req drops.
    } store_state_t;

    // UART transmitter.
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_SHIFT,
        TX_DONE
    } tx_state_t;

endpackage

/* photon_pulse_counter.sv */
`timescale 1ns/1ps

module photon_pulse_counter (
    input  logic                       clk_133MHz_210,
    input  logic                       rst_n,
    input  logic                       photon_pulse,  // Raw photon pin.
    input  logic                       sync_50hz,     // Raw 50 Hz sync pin.
    output photon_counter_pkg::count_t win_count,     // Last closed window.
    output photon_counter_pkg::count_t accum_count,   // Sum of closed windows.
    output logic                       win_valid      // One cycle per sync edge.
);

    logic [1:0] photon_meta;  // Two-flop synchronizer.
    logic [1:0] sync_meta;
    logic       photon_last;  // Delayed copy for edge detect.
    logic       sync_last;
    logic       photon_rise;
    logic       sync_rise;

    photon_counter_pkg::count_t run_count;  // Open window count.

    ////////////////////////////////////////////////////////////
    // Input synchronizers and edge detectors.
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            photon_meta <= 2'b00;
            sync_meta   <= 2'b00;
            photon_last <= 1'b0;
            sync_last   <= 1'b0;
        end else begin
            photon_meta <= {photon_meta[0], photon_pulse};
            sync_meta   <= {sync_meta[0], sync_50hz};
            photon_last <= photon_meta[1];
            sync_last   <= sync_meta[1];
        end
    end

    assign photon_rise = photon_meta[1] & ~photon_last;  // Rising photon.
    assign sync_rise   = sync_meta[1] & ~sync_last;      // Window boundary.

    ////////////////////////////////////////////////////////////
    // Window counting.
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            run_count   <= '0;  // First window opens here.
            win_count   <= '0;
            accum_count <= '0;
            win_valid   <= 1'b0;
        end else begin
            win_valid <= sync_rise;  // Lines up with win_count.
            if (sync_rise) begin
                // Close the window.
                win_count   <= run_count;
                accum_count <= accum_count + run_count;
                // Coincident photon opens the new window.
                run_count   <= photon_counter_pkg::count_t'(photon_rise);
            end else if (photon_rise) begin
                run_count <= run_count + 1'b1;
            end
        end
    end

endmodule

/* history_store.sv */
`timescale 1ns/1ps

module history_store (
    input  logic                           clk_133MHz_210,
    input  logic                           rst_n,
    // Logger write port.
    input  logic                           wr_req,
    input  photon_counter_pkg::hist_addr_t wr_addr,
    input  photon_counter_pkg::count_t     wr_data,
    output logic                           wr_ack,
    // Logger read port.
    input  logic                           rd_req,
    input  photon_counter_pkg::hist_addr_t rd_addr,
    output photon_counter_pkg::count_t     rd_data,
    output logic                           rd_ack,
    // Host read port.
    input  logic                           host_rd_req,
    input  photon_counter_pkg::hist_addr_t host_rd_addr,
    output photon_counter_pkg::count_t     host_rd_data,
    output logic                           host_rd_ack
);

    photon_counter_pkg::store_state_t state;
    photon_counter_pkg::count_t       mem [photon_counter_pkg::HIST_DEPTH];
    logic                             release_done;

    // Only the granted client has ack high.
    assign release_done = (wr_ack & ~wr_req) | (rd_ack & ~rd_req)
                        | (host_rd_ack & ~host_rd_req);

    ////////////////////////////////////////////////////////////
    // Fixed priority arbiter: write, logger read, host read.
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            state       <= photon_counter_pkg::ST_IDLE;
            wr_ack      <= 1'b0;
            rd_ack      <= 1'b0;
            host_rd_ack <= 1'b0;
        end else begin
            case (state)
                photon_counter_pkg::ST_IDLE: begin
                    if (wr_req) state <= photon_counter_pkg::ST_SERVE_WR;
                    else if (rd_req) state <= photon_counter_pkg::ST_SERVE_RD;
                    else if (host_rd_req) state <= photon_counter_pkg::ST_SERVE_HOST;
                end
                photon_counter_pkg::ST_SERVE_WR: begin
                    wr_ack <= 1'b1;  // Write lands this cycle.
                    state  <= photon_counter_pkg::ST_RELEASE;
                end
                photon_counter_pkg::ST_SERVE_RD: begin
                    rd_ack <= 1'b1;  // Data registered alongside.
                    state  <= photon_counter_pkg::ST_RELEASE;
                end
                photon_counter_pkg::ST_SERVE_HOST: begin
                    host_rd_ack <= 1'b1;
                    state       <= photon_counter_pkg::ST_RELEASE;
                end
                photon_counter_pkg::ST_RELEASE: begin
                    if (release_done) begin  // Req fell, close handshake.
                        wr_ack      <= 1'b0;
                        rd_ack      <= 1'b0;
                        host_rd_ack <= 1'b0;
                        state       <= photon_counter_pkg::ST_IDLE;
                    end
                end
                default: state <= photon_counter_pkg::ST_IDLE;
            endcase
        end
    end

    // History memory, zero after reset.
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < photon_counter_pkg::HIST_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (state == photon_counter_pkg::ST_SERVE_WR) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read data, valid while ack is high.
    always_ff @(posedge clk_133MHz_210) begin
        if (state == photon_counter_pkg::ST_SERVE_RD) rd_data <= mem[rd_addr];
        if (state == photon_counter_pkg::ST_SERVE_HOST) host_rd_data <= mem[host_rd_addr];
    end

endmodule

/* window_logger.sv */
`timescale 1ns/1ps

module window_logger (
    input  logic                           clk_133MHz_210,
    input  logic                           rst_n,
    // From the pulse counter.
    input  photon_counter_pkg::count_t     win_count,
    input  logic                           win_valid,
    // History write.
    output logic                           wr_req,
    output photon_counter_pkg::hist_addr_t wr_addr,
    output photon_counter_pkg::count_t     wr_data,
    input  logic                           wr_ack,
    // History read back.
    output logic                           rd_req,
    output photon_counter_pkg::hist_addr_t rd_addr,
    input  photon_counter_pkg::count_t     rd_data,
    input  logic                           rd_ack,
    // UART byte port.
    output logic                           tx_req,
    output logic [7:0]                     tx_byte,
    input  logic                           tx_ack
);

    photon_counter_pkg::logger_state_t state;
    photon_counter_pkg::hist_addr_t    hist_idx;   // Current slot, wraps at 16.
    photon_counter_pkg::count_t        read_back;  // Value fetched from memory.

    logic [$clog2(photon_counter_pkg::BYTES_PER_COUNT)-1:0] byte_idx;  // 0 is MSB.

    // Write and read back the same slot.
    assign wr_addr = hist_idx;
    assign rd_addr = hist_idx;

    ////////////////////////////////////////////////////////////
    // Step sequencer: write, read back, send four bytes.
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            state     <= photon_counter_pkg::LOG_IDLE;
            hist_idx  <= '0;
            byte_idx  <= '0;
            wr_req    <= 1'b0;
            rd_req    <= 1'b0;
            tx_req    <= 1'b0;
            wr_data   <= '0;
            read_back <= '0;
            tx_byte   <= 8'h00;
        end else begin
            case (state)
                photon_counter_pkg::LOG_IDLE: begin
                    // Windows closing while busy are not logged.
                    if (win_valid) begin
                        wr_data <= win_count;
                        wr_req  <= 1'b1;
                        state   <= photon_counter_pkg::LOG_WRITE;
                    end
                end
                photon_counter_pkg::LOG_WRITE: begin
                    if (wr_req && wr_ack) begin
                        wr_req <= 1'b0;  // Write accepted.
                    end else if (!wr_req && !wr_ack) begin
                        rd_req <= 1'b1;  // Handshake closed, start read.
                        state  <= photon_counter_pkg::LOG_READ;
                    end
                end
                photon_counter_pkg::LOG_READ: begin
                    if (rd_req && rd_ack) begin
                        read_back <= rd_data;  // Valid with ack.
                        rd_req    <= 1'b0;
                    end else if (!rd_req && !rd_ack) begin
                        byte_idx <= '0;
                        state    <= photon_counter_pkg::LOG_SEND_REQ;
                    end
                end
                photon_counter_pkg::LOG_SEND_REQ: begin
                    // Byte and req go out together.
                    tx_byte <= read_back[(photon_counter_pkg::BYTES_PER_COUNT - 1
                                          - byte_idx) * 8 +: 8];
                    tx_req  <= 1'b1;
                    state   <= photon_counter_pkg::LOG_SEND_WAIT;
                end
                photon_counter_pkg::LOG_SEND_WAIT: begin
                    if (tx_ack) begin  // Frame is on the line.
                        tx_req <= 1'b0;
                        state  <= photon_counter_pkg::LOG_NEXT_BYTE;
                    end
                end
                photon_counter_pkg::LOG_NEXT_BYTE: begin
                    if (!tx_ack) begin
                        if (byte_idx == photon_counter_pkg::BYTES_PER_COUNT - 1) begin
                            hist_idx <= hist_idx + 1'b1;  // Next slot.
                            state    <= photon_counter_pkg::LOG_IDLE;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                            state    <= photon_counter_pkg::LOG_SEND_REQ;
                        end
                    end
                end
                default: state <= photon_counter_pkg::LOG_IDLE;
            endcase
        end
    end

endmodule

/* uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
    input  logic       clk_133MHz_210,
    input  logic       rst_n,
    input  logic       tx_req,    // Four-phase request.
    input  logic [7:0] tx_byte,   // Held while tx_req is high.
    output logic       tx_ack,
    output logic       uart_txd   // Idles high.
);

    photon_counter_pkg::tx_state_t state;

    logic [photon_counter_pkg::FRAME_BITS-1:0]         frame;     // Bit 0 on the line.
    logic [$clog2(photon_counter_pkg::BAUD_DIV)-1:0]   baud_cnt;  // Cycles in this bit.
    logic [$clog2(photon_counter_pkg::FRAME_BITS)-1:0] bit_cnt;   // Bits sent so far.

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            state    <= photon_counter_pkg::TX_IDLE;
            frame    <= '1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            tx_ack   <= 1'b0;
            uart_txd <= 1'b1;
        end else begin
            case (state)
                photon_counter_pkg::TX_IDLE: begin
                    if (tx_req) begin
                        frame    <= {2'b11, tx_byte, 1'b0};  // Stop, data, start.
                        uart_txd <= 1'b0;                    // Start bit now.
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= photon_counter_pkg::TX_SHIFT;
                    end
                end
                photon_counter_pkg::TX_SHIFT: begin
                    if (baud_cnt == photon_counter_pkg::BAUD_DIV - 1) begin
                        baud_cnt <= '0;
                        if (bit_cnt == photon_counter_pkg::FRAME_BITS - 1) begin
                            tx_ack <= 1'b1;  // Second stop bit done.
                            state  <= photon_counter_pkg::TX_DONE;
                        end else begin
                            uart_txd <= frame[1];  // Next bit, LSB first.
                            frame    <= frame >> 1;
                            bit_cnt  <= bit_cnt + 1'b1;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                photon_counter_pkg::TX_DONE: begin
                    if (!tx_req) begin  // Close the handshake.
                        tx_ack <= 1'b0;
                        state  <= photon_counter_pkg::TX_IDLE;
                    end
                end
                default: state <= photon_counter_pkg::TX_IDLE;
            endcase
        end
    end

endmodule

/* single_photon_counter.sv */
`timescale 1ns/1ps

module single_photon_counter (
    input  logic                           clk_133MHz_210,
    input  logic                           rst_n,
    input  logic                           photon_pulse,  // Detector output.
    input  logic                           sync_50hz,     // Window sync.
    output logic                           uart_txd,
    output photon_counter_pkg::count_t     accum_count,   // Running total.
    // Host history read port.
    input  logic                           host_rd_req,
    input  photon_counter_pkg::hist_addr_t host_rd_addr,
    output logic                           host_rd_ack,
    output photon_counter_pkg::count_t     host_rd_data
);

    photon_counter_pkg::count_t     win_count;
    logic                           win_valid;

    // Logger to memory.
    logic                           wr_req;
    logic                           wr_ack;
    photon_counter_pkg::hist_addr_t wr_addr;
    photon_counter_pkg::count_t     wr_data;
    logic                           rd_req;
    logic                           rd_ack;
    photon_counter_pkg::hist_addr_t rd_addr;
    photon_counter_pkg::count_t     rd_data;

    // Logger to UART.
    logic                           tx_req;
    logic                           tx_ack;
    logic [7:0]                     tx_byte;

    ////////////////////////////////////////////////////////////
    photon_pulse_counter u_counter (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .photon_pulse   (photon_pulse),
        .sync_50hz      (sync_50hz),
        .win_count      (win_count),
        .accum_count    (accum_count),
        .win_valid      (win_valid)
    );

    history_store u_store (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .wr_req         (wr_req),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .wr_ack         (wr_ack),
        .rd_req         (rd_req),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data),
        .rd_ack         (rd_ack),
        .host_rd_req    (host_rd_req),
        .host_rd_addr   (host_rd_addr),
        .host_rd_data   (host_rd_data),
        .host_rd_ack    (host_rd_ack)
    );

    window_logger u_logger (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .win_count      (win_count),
        .win_valid      (win_valid),
        .wr_req         (wr_req),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .wr_ack         (wr_ack),
        .rd_req         (rd_req),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data),
        .rd_ack         (rd_ack),
        .tx_req         (tx_req),
        .tx_byte        (tx_byte),
        .tx_ack         (tx_ack)
    );

    uart_tx u_uart (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .tx_req         (tx_req),
        .tx_byte        (tx_byte),
        .tx_ack         (tx_ack),
        .uart_txd       (uart_txd)
    );

endmodule

/* tb_single_photon_counter.sv */
`timescale 1ns/1ps

module tb_single_photon_counter;

    localparam int NUM_WIN       = 5;     // Windows logged by the test.
    localparam int REPORT_CYCLES = photon_counter_pkg::FRAME_BITS
                                 * photon_counter_pkg::BYTES_PER_COUNT
                                 * photon_counter_pkg::BAUD_DIV;
    localparam int WIN_CYCLES    = REPORT_CYCLES + 2000;  // Report plus margin.
    localparam int HOST_TIMEOUT  = 64;                    // Cycles per handshake phase.
    localparam int WATCHDOG_NS   = 2 * ((NUM_WIN + 2) * WIN_CYCLES
                                 + 40 * HOST_TIMEOUT) * 8;

    logic                           clk_133MHz_210 = 1'b0;
    logic                           rst_n;
    logic                           photon_pulse;
    logic                           sync_50hz;
    logic                           uart_txd;
    photon_counter_pkg::count_t     accum_count;
    logic                           host_rd_req;
    photon_counter_pkg::hist_addr_t host_rd_addr;
    logic                           host_rd_ack;
    photon_counter_pkg::count_t     host_rd_data;

    logic [15:0]                    lfsr_state;
    int                             errors = 0;
    int                             checks = 0;
    photon_counter_pkg::count_t     win_counts [NUM_WIN];      // Pulses driven per window.
    logic [7:0]                     rx_bytes [NUM_WIN * 4];    // Decoded UART bytes.
    int                             rx_count = 0;
    logic                           compare_done = 1'b0;

    single_photon_counter dut (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .photon_pulse   (photon_pulse),
        .sync_50hz      (sync_50hz),
        .uart_txd       (uart_txd),
        .accum_count    (accum_count),
        .host_rd_req    (host_rd_req),
        .host_rd_addr   (host_rd_addr),
        .host_rd_ack    (host_rd_ack),
        .host_rd_data   (host_rd_data)
    );

    always #4 clk_133MHz_210 = ~clk_133MHz_210;  // 125 MHz stand-in, 8 ns.

    ////////////////////////////////////////////////////////////
    // Helpers.
    ////////////////////////////////////////////////////////////
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_133MHz_210);
        #1;  // Land just after the edge.
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    // Galois LFSR, taps 16,14,13,11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic random_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);  // One step per bit.
            val        = (val << 1) | lfsr_state[0];
        end
    endtask

    // Byte pos of a report, MSB first.
    function automatic logic [7:0] ref_byte(input logic [31:0] count, input int pos);
        logic [31:0] shifted;
        shifted  = count >> (8 * (photon_counter_pkg::BYTES_PER_COUNT - 1 - pos));
        ref_byte = shifted[7:0];
    endfunction

    // Random burst of pulses, returns count and cycles spent.
    task automatic drive_pulses(output int n_pulses, output int used);
        int gap;
        random_bits(6, n_pulses);  // 0 to 63 pulses.
        used = 0;
        for (int i = 0; i < n_pulses; i++) begin
            photon_pulse = 1'b1;
            wait_cycles(2);
            photon_pulse = 1'b0;
            random_bits(4, gap);
            wait_cycles(4 + gap);  // At least 4 low cycles.
            used += 6 + gap;
        end
    endtask

    task automatic host_read(input int addr, input logic [31:0] exp);
        int waited;
        waited       = 0;
        host_rd_addr = photon_counter_pkg::hist_addr_t'(addr);
        host_rd_req  = 1'b1;
        while (!host_rd_ack && waited < HOST_TIMEOUT) begin
            wait_cycles(1);
            waited++;
        end
        if (!host_rd_ack) begin
            errors++;
            $display("Host read of entry %0d was never acknowledged", addr);
        end else begin
            check_value("host_rd_data", host_rd_data, exp);  // Valid with ack.
        end
        host_rd_req = 1'b0;
        waited      = 0;
        while (host_rd_ack && waited < HOST_TIMEOUT) begin
            wait_cycles(1);
            waited++;
        end
        if (host_rd_ack) begin
            errors++;
            $display("Host acknowledge for entry %0d stayed high after the request fell", addr);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus.
    ////////////////////////////////////////////////////////////
    initial begin
        int          used;
        int          n_pulses;
        logic [31:0] total;
        rst_n        = 1'b0;
        photon_pulse = 1'b0;
        sync_50hz    = 1'b0;
        host_rd_req  = 1'b0;
        host_rd_addr = '0;
        lfsr_state   = 16'd45721;
        total        = '0;
        repeat (5) @(posedge clk_133MHz_210);
        #1;
        rst_n = 1'b1;  // First window opens here.
        wait_cycles(2);

        // Idle state after reset.
        check_value("uart_txd", uart_txd, 1);
        check_value("host_rd_ack", host_rd_ack, 0);
        check_value("accum_count", accum_count, 0);
        for (int a = 0; a < photon_counter_pkg::HIST_DEPTH; a++) host_read(a, 0);

        for (int w = 0; w < NUM_WIN; w++) begin
            drive_pulses(n_pulses, used);
            win_counts[w] = n_pulses;
            total        += n_pulses;
            wait_cycles(WIN_CYCLES - used);  // Let the last report finish.
            sync_50hz = 1'b1;                // Closes window w.
            wait_cycles(4);
            if (w == 2) host_read(1, win_counts[1]);  // Contends with the logger.
            wait_cycles(4);
            sync_50hz = 1'b0;
            wait_cycles(4);
        end

        wait (compare_done);
        check_value("accum_count", accum_count, total);
        for (int a = 0; a < photon_counter_pkg::HIST_DEPTH; a++) begin
            host_read(a, (a < NUM_WIN) ? win_counts[a] : 32'd0);
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // UART decoder, mid-bit sampling.
    ////////////////////////////////////////////////////////////
    initial begin
        logic [7:0] data;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge uart_txd);  // Start bit edge.
            wait_cycles(photon_counter_pkg::BAUD_DIV / 2);
            check_value("uart_txd start bit", uart_txd, 0);
            for (int i = 0; i < 8; i++) begin
                wait_cycles(photon_counter_pkg::BAUD_DIV);
                data[i] = uart_txd;  // LSB first.
            end
            wait_cycles(photon_counter_pkg::BAUD_DIV);
            check_value("uart_txd stop bit 1", uart_txd, 1);
            wait_cycles(photon_counter_pkg::BAUD_DIV);
            check_value("uart_txd stop bit 2", uart_txd, 1);
            if (rx_count < NUM_WIN * 4) begin
                rx_bytes[rx_count] = data;
                rx_count++;
            end else begin
                errors++;
                $display("The UART sent more bytes than the windows account for");
            end
        end
    end

    // Compares each report with the reference.
    initial begin
        for (int w = 0; w < NUM_WIN; w++) begin
            for (int b = 0; b < photon_counter_pkg::BYTES_PER_COUNT; b++) begin
                wait (rx_count > w * 4 + b);
                check_value("uart_txd byte", rx_bytes[w * 4 + b], ref_byte(win_counts[w], b));
            end
        end
        compare_done = 1'b1;
    end

    // Watchdog.
    initial begin
        #(WATCHDOG_NS);
        $display("The run timed out before all reports and host reads were done");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* single_photon_counter.f */
photon_counter_pkg.sv
photon_pulse_counter.sv
history_store.sv
window_logger.sv
uart_tx.sv
single_photon_counter.sv
tb_single_photon_counter.sv
